// ==== all.f ====
+incdir+rtl
rtl/mseq_pkg.sv
rtl/mseq_if.sv
rtl/micro_rom.sv
rtl/seq_control.sv
rtl/op_datapath.sv
rtl/microseq_top.sv
verif/clk_gen.sv
verif/arith_model.sv
verif/tb_microseq.sv

// ==== Bender.yml ====
package:
  name: microseq

export_include_dirs:
  - rtl

sources:
  - rtl/mseq_pkg.sv
  - rtl/mseq_if.sv
  - rtl/micro_rom.sv
  - rtl/seq_control.sv
  - rtl/op_datapath.sv
  - rtl/microseq_top.sv
  - target: test
    files:
      - verif/clk_gen.sv
      - verif/arith_model.sv
      - verif/tb_microseq.sv

// ==== verif/tb_microseq.sv ====
module tb_microseq;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS        = 13;
    localparam int WATCHDOG_CYCLES = 16 + NUM_ROWS * 64;  // Reset plus budget per row

    logic                clk;
    logic                reset;
    logic                start;
    mseq_pkg::prog_idx_t micro_program_index;
    logic                instruction_complete;
    mseq_pkg::fp80_t     data_in;
    mseq_pkg::fp80_t     data_out;
    mseq_pkg::arith_op_t arith_operation;
    logic                arith_enable;
    mseq_pkg::fp80_t     arith_operand_a;
    mseq_pkg::fp80_t     arith_operand_b;
    mseq_pkg::fp80_t     arith_result;
    logic                arith_done;
    int                  call_count;
    mseq_pkg::arith_op_t last_op;

    // Stimulus table with one column per array
    string               row_name   [NUM_ROWS];
    mseq_pkg::prog_idx_t row_idx    [NUM_ROWS];
    mseq_pkg::fp80_t     row_a      [NUM_ROWS];
    mseq_pkg::fp80_t     row_b      [NUM_ROWS];
    int                  row_calls  [NUM_ROWS];
    mseq_pkg::arith_op_t row_op     [NUM_ROWS];  // Last op code expected
    mseq_pkg::fp80_t     row_result [NUM_ROWS];
    bit                  row_poke   [NUM_ROWS];  // Extra start mid-program

    mseq_pkg::fp80_t held_a;  // Operands the DUT should be holding
    mseq_pkg::fp80_t held_b;

    int data_errors;
    int op_errors;
    int count_errors;
    int flag_errors;

    clk_gen clk_i (.clk(clk), .reset(reset));

    microseq_top dut_i (
        .clk                  (clk),
        .reset                (reset),
        .start                (start),
        .micro_program_index  (micro_program_index),
        .instruction_complete (instruction_complete),
        .data_in              (data_in),
        .data_out             (data_out),
        .arith_operation      (arith_operation),
        .arith_enable         (arith_enable),
        .arith_operand_a      (arith_operand_a),
        .arith_operand_b      (arith_operand_b),
        .arith_result         (arith_result),
        .arith_done           (arith_done)
    );

    arith_model arith_i (
        .clk             (clk),
        .reset           (reset),
        .arith_enable    (arith_enable),
        .arith_operation (arith_operation),
        .arith_operand_a (arith_operand_a),
        .arith_operand_b (arith_operand_b),
        .arith_result    (arith_result),
        .arith_done      (arith_done),
        .call_count      (call_count),
        .last_op         (last_op)
    );

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------

    task automatic check_fp(input string name, input string what,
                            input mseq_pkg::fp80_t exp, input mseq_pkg::fp80_t act);
        if (act !== exp) begin
            data_errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_op(input string name, input mseq_pkg::arith_op_t exp,
                            input mseq_pkg::arith_op_t act);
        if (act !== exp) begin
            op_errors++;
            $display("[FAIL] %s last op: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            count_errors++;
            $display("[FAIL] %s calls: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // ------------------------------------------------------------------------
    // Table
    // ------------------------------------------------------------------------

    task automatic add_row(input int i, input string name, input mseq_pkg::prog_idx_t idx,
                           input mseq_pkg::fp80_t a, input mseq_pkg::fp80_t b,
                           input int calls, input mseq_pkg::arith_op_t op,
                           input mseq_pkg::fp80_t result, input bit poke);
        row_name[i]   = name;
        row_idx[i]    = idx;
        row_a[i]      = a;
        row_b[i]      = b;
        row_calls[i]  = calls;
        row_op[i]     = op;
        row_result[i] = result;
        row_poke[i]   = poke;
    endtask

    // Result is A + B + op mod 2^80 on the held operands
    task automatic load_table();
        add_row(0, "FADD", 4'd0, 80'h1000, 80'h0234, 1, 5'd0, 80'h1234, 1'b0);
        add_row(1, "FSUB wrap", 4'd1, {80{1'b1}}, 80'h2, 1, 5'd1, 80'h2, 1'b0);
        add_row(2, "FMUL wrap", 4'd2, 80'h8000_0000_0000_0000_0000,
                80'h8000_0000_0000_0000_0010, 1, 5'd2, 80'h12, 1'b0);
        add_row(3, "FDIV", 4'd3, 80'h1234_5678_9ABC_DEF0_1111, 80'h2222, 1, 5'd3,
                80'h1234_5678_9ABC_DEF0_3336, 1'b0);
        add_row(4, "FSQRT", 4'd4, 80'h50, 80'hDEAD, 1, 5'd12, 80'h227E, 1'b0);  // Old B
        add_row(5, "FSIN", 4'd5, 80'hAAAA, 80'hBBBB, 1, 5'd13, 80'h227F, 1'b0);
        add_row(6, "FCOS", 4'd6, 80'hAAAA, 80'hBBBB, 1, 5'd14, 80'h2280, 1'b0);
        add_row(7, "FPREM", 4'd9, 80'hCCCC, 80'hDDDD, 3, 5'd1, 80'h2273, 1'b0);
        // Empty entries halt and leave data_out and last op alone
        add_row(8, "index 7", 4'd7, 80'h1, 80'h2, 0, 5'd1, 80'h2273, 1'b0);
        add_row(9, "index 8", 4'd8, 80'h1, 80'h2, 0, 5'd1, 80'h2273, 1'b0);
        add_row(10, "index 10", 4'd10, 80'h1, 80'h2, 0, 5'd1, 80'h2273, 1'b0);
        add_row(11, "index 15", 4'd15, 80'h1, 80'h2, 0, 5'd1, 80'h2273, 1'b0);
        add_row(12, "FADD busy start", 4'd0, 80'h7, 80'h9, 1, 5'd0, 80'h10, 1'b1);
    endtask

    task automatic run_row(input int i);
        int calls_before;
        calls_before = call_count;
        @(posedge clk);
        start               <= 1'b1;
        micro_program_index <= row_idx[i];
        data_in             <= row_a[i];
        @(posedge clk);  // Start accepted
        start <= 1'b0;
        repeat (2) @(posedge clk);
        @(posedge clk);  // LOAD_A takes A here
        data_in <= row_b[i];
        if (row_poke[i]) begin
            @(posedge clk);
            start               <= 1'b1;  // Seen in DECODE
            micro_program_index <= 4'd9;
            @(posedge clk);
            start <= 1'b0;
        end
        @(negedge clk);
        while (!instruction_complete)
            @(negedge clk);
        // Programs 0 to 4 load A, only 0 to 3 load B
        if (row_idx[i] <= 4'd4)
            held_a = row_a[i];
        if (row_idx[i] <= 4'd3)
            held_b = row_b[i];
        check_fp(row_name[i], "data_out", row_result[i], data_out);
        check_fp(row_name[i], "operand a", held_a, arith_operand_a);
        check_fp(row_name[i], "operand b", held_b, arith_operand_b);
        check_count(row_name[i], row_calls[i], call_count - calls_before);
        check_op(row_name[i], row_op[i], last_op);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------

    initial begin
        int total;
        start               = 1'b0;
        micro_program_index = '0;
        data_in             = '0;
        held_a              = '0;
        held_b              = '0;
        data_errors         = 0;
        op_errors           = 0;
        count_errors        = 0;
        flag_errors         = 0;
        load_table();
        @(negedge reset);
        @(negedge clk);
        check_flag("reset instruction_complete", 1'b0, instruction_complete);
        check_flag("reset arith_enable", 1'b0, arith_enable);
        check_fp("reset", "data_out", '0, data_out);
        for (int i = 0; i < NUM_ROWS; i++)
            run_row(i);
        total = data_errors + op_errors + count_errors + flag_errors;
        $display("Errors: data %0d, op code %0d, calls %0d, flags %0d",
                 data_errors, op_errors, count_errors, flag_errors);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: program did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== verif/arith_model.sv ====
module arith_model (
    input  logic                clk,
    input  logic                reset,
    input  logic                arith_enable,
    input  mseq_pkg::arith_op_t arith_operation,
    input  mseq_pkg::fp80_t     arith_operand_a,
    input  mseq_pkg::fp80_t     arith_operand_b,
    output mseq_pkg::fp80_t     arith_result,
    output logic                arith_done,
    output int                  call_count,  // Enable pulses seen
    output mseq_pkg::arith_op_t last_op
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0]     rng;
    int              remaining;  // Cycles until done rises
    mseq_pkg::fp80_t pending;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Outputs defined before the first reset edge
    initial begin
        arith_result = '0;
        arith_done   = 1'b0;
        call_count   = 0;
        last_op      = '0;
    end

    // ------------------------------------------------------------------------
    // Done is a level, dropped only by the next enable
    // ------------------------------------------------------------------------

    always @(posedge clk or posedge reset) begin : model_step
        logic [31:0] rng_next;
        if (reset) begin
            arith_result <= '0;
            arith_done   <= 1'b0;
            call_count   <= 0;
            last_op      <= '0;
            remaining    <= 0;
            rng          <= 32'd41700;
        end else if (arith_enable) begin
            rng_next   = xorshift32(rng);
            rng        <= rng_next;
            remaining  <= int'(rng_next % 32'd8) + 1;  // 1 to 8 cycles
            pending    <= arith_operand_a + arith_operand_b
                          + mseq_pkg::fp80_t'(arith_operation);  // Wraps at 2^80
            last_op    <= arith_operation;
            call_count <= call_count + 1;
            arith_done <= 1'b0;
        end else if (remaining > 0) begin
            remaining <= remaining - 1;
            if (remaining == 1) begin
                arith_done   <= 1'b1;
                arith_result <= pending;
            end
        end
    end

endmodule

// ==== verif/clk_gen.sv ====
module clk_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    // Free running, 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);  // 16 cycles in reset
        @(negedge clk);              // Release away from the active edge
        reset = 1'b0;
    end

endmodule

// ==== rtl/microseq_top.sv ====
module microseq_top (
    input  logic                clk,
    input  logic                reset,
    // Host side
    input  logic                start,
    input  mseq_pkg::prog_idx_t micro_program_index,
    output logic                instruction_complete,
    input  mseq_pkg::fp80_t     data_in,
    output mseq_pkg::fp80_t     data_out,
    // Arithmetic unit side
    output mseq_pkg::arith_op_t arith_operation,
    output logic                arith_enable,
    output mseq_pkg::fp80_t     arith_operand_a,
    output mseq_pkg::fp80_t     arith_operand_b,
    input  mseq_pkg::fp80_t     arith_result,
    input  logic                arith_done
);

    rom_if  rom_bus ();
    exec_if ex_bus ();

    micro_rom u_rom (
        .rom (rom_bus.rom)
    );

    seq_control u_seq (
        .clk                  (clk),
        .reset                (reset),
        .start                (start),
        .micro_program_index  (micro_program_index),
        .instruction_complete (instruction_complete),
        .arith_done           (arith_done),
        .rom                  (rom_bus.seq),
        .ex                   (ex_bus.ctl)
    );

    op_datapath u_dp (
        .clk             (clk),
        .reset           (reset),
        .data_in         (data_in),
        .data_out        (data_out),
        .arith_operation (arith_operation),
        .arith_enable    (arith_enable),
        .arith_operand_a (arith_operand_a),
        .arith_operand_b (arith_operand_b),
        .arith_result    (arith_result),
        .arith_done      (arith_done),
        .ex              (ex_bus.dp)
    );

endmodule

// ==== rtl/op_datapath.sv ====
`include "mseq_config.svh"

module op_datapath (
    input  logic                clk,
    input  logic                reset,
    input  mseq_pkg::fp80_t     data_in,
    output mseq_pkg::fp80_t     data_out,
    output mseq_pkg::arith_op_t arith_operation,
    output logic                arith_enable,
    output mseq_pkg::fp80_t     arith_operand_a,
    output mseq_pkg::fp80_t     arith_operand_b,
    input  mseq_pkg::fp80_t     arith_result,
    input  logic                arith_done,
    exec_if.dp                  ex
);

    mseq_pkg::fp80_t op_a;    // Held across programs
    mseq_pkg::fp80_t op_b;
    mseq_pkg::fp80_t result;

    // ------------------------------------------------------------------------
    // Control and bus output
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            arith_enable  <= 1'b0;
            ex.arith_busy <= 1'b0;
            data_out      <= '0;
        end else begin
            arith_enable <= 1'b0;  // Single cycle launch
            if (ex.exec_stb && ex.micro_op == mseq_pkg::MOP_CALL_ARITH) begin
                arith_enable  <= 1'b1;
                ex.arith_busy <= 1'b1;
            end else if (ex.arith_busy && arith_done && !arith_enable) begin
                // Old done level still up during the enable cycle
                ex.arith_busy <= 1'b0;
            end
            if (ex.exec_stb && ex.micro_op == mseq_pkg::MOP_STORE)
                data_out <= result;
        end
    end

    // Operands, result and launch payload
    always_ff @(posedge clk) begin
        if (ex.exec_stb) begin
            case (ex.micro_op)
                mseq_pkg::MOP_LOAD_A: op_a <= data_in;
                mseq_pkg::MOP_LOAD_B: op_b <= data_in;
                mseq_pkg::MOP_CALL_ARITH: begin
                    arith_operation <= ex.imm[`MSEQ_OP_W-1:0];
                    arith_operand_a <= op_a;
                    arith_operand_b <= op_b;
                end
                mseq_pkg::MOP_LOAD_ARITH_RES: result <= arith_result;
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    a_enable_pulse: assert property (@(posedge clk) disable iff (reset)
        arith_enable |=> !arith_enable)
        else $error("arith_enable held two cycles");

    // Sequencer wait must cover the whole operation
    a_res_not_busy: assert property (@(posedge clk) disable iff (reset)
        ex.exec_stb && ex.micro_op == mseq_pkg::MOP_LOAD_ARITH_RES |-> !ex.arith_busy)
        else $error("LOAD_ARITH_RES while busy");

endmodule

// ==== rtl/seq_control.sv ====
`include "mseq_config.svh"

module seq_control (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  mseq_pkg::prog_idx_t micro_program_index,
    output logic                instruction_complete,
    input  logic                arith_done,
    rom_if.seq                  rom,
    exec_if.ctl                 ex
);

    mseq_pkg::seq_state_e state;
    mseq_pkg::uaddr_t     pc;
    mseq_pkg::uinstr_t    instr_q;    // Word fetched for this step
    mseq_pkg::opcode_e    opcode;
    mseq_pkg::uaddr_t     next_addr;
    logic                 wait_hold;  // Stay parked in WAIT

    // ------------------------------------------------------------------------
    // Instruction fields
    // ------------------------------------------------------------------------

    assign opcode      = mseq_pkg::opcode_e'(instr_q[31:28]);
    assign ex.micro_op = mseq_pkg::micro_op_e'(instr_q[27:23]);
    assign ex.imm      = instr_q[22:15];
    assign next_addr   = instr_q[`MSEQ_ADDR_W-1:0];  // Bits 14:12 reserved

    assign rom.prog_idx   = micro_program_index;  // Entry looked up in IDLE
    assign rom.fetch_addr = pc;

    assign ex.exec_stb = (state == mseq_pkg::ST_EXEC) && (opcode == mseq_pkg::OPC_EXEC);

    // Park only while the launched op is still out
    assign wait_hold = (ex.micro_op == mseq_pkg::MOP_WAIT_ARITH) && ex.arith_busy
                       && !arith_done;

    always_ff @(posedge clk) begin
        if (state == mseq_pkg::ST_FETCH)
            instr_q <= rom.instr;
    end

    // ------------------------------------------------------------------------
    // Sequencer FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state                <= mseq_pkg::ST_IDLE;
            pc                   <= '0;
            instruction_complete <= 1'b0;
        end else begin
            case (state)
                mseq_pkg::ST_IDLE: begin
                    if (start) begin
                        pc                   <= rom.entry_addr;
                        instruction_complete <= 1'b0;  // Level drops on new program
                        state                <= mseq_pkg::ST_FETCH;
                    end
                end
                mseq_pkg::ST_FETCH:  state <= mseq_pkg::ST_DECODE;
                mseq_pkg::ST_DECODE: state <= mseq_pkg::ST_EXEC;
                mseq_pkg::ST_EXEC: begin
                    if (opcode == mseq_pkg::OPC_EXEC) begin
                        if (wait_hold) begin
                            state <= mseq_pkg::ST_WAIT;
                        end else begin
                            pc    <= next_addr;
                            state <= mseq_pkg::ST_FETCH;
                        end
                    end else begin
                        // RET and HALT both finish the program
                        instruction_complete <= 1'b1;
                        state                <= mseq_pkg::ST_IDLE;
                    end
                end
                mseq_pkg::ST_WAIT: begin
                    if (arith_done) begin  // Leave the cycle after done seen
                        pc    <= next_addr;
                        state <= mseq_pkg::ST_FETCH;
                    end
                end
                default: state <= mseq_pkg::ST_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // No arithmetic op left in flight when a program ends
    a_complete_from_exec: assert property (@(posedge clk) disable iff (reset)
        $rose(instruction_complete) |-> $past(state) == mseq_pkg::ST_EXEC && !ex.arith_busy)
        else $error("instruction_complete rose outside EXEC or with an op in flight");

    // Strobe only right after DECODE and with a micro-op the datapath knows
    a_stb_in_exec: assert property (@(posedge clk) disable iff (reset)
        ex.exec_stb |-> $past(state) == mseq_pkg::ST_DECODE
                        && ex.micro_op inside {mseq_pkg::MOP_STORE, mseq_pkg::MOP_LOAD_A,
                                               mseq_pkg::MOP_LOAD_B, mseq_pkg::MOP_CALL_ARITH,
                                               mseq_pkg::MOP_WAIT_ARITH,
                                               mseq_pkg::MOP_LOAD_ARITH_RES})
        else $error("exec_stb outside EXEC or with an unknown micro-op");

endmodule

// ==== rtl/micro_rom.sv ====
module micro_rom (
    rom_if.rom rom
);

    logic [2:0]       prog;    // Slot within the 0x100 block
    logic [3:0]       step;    // Word within a program
    logic [3:0]       n_load;  // Operand loads ahead of the call
    mseq_pkg::imm_t   op_imm;  // Arithmetic op of the slot
    mseq_pkg::uaddr_t nxt;     // Programs run straight through

    function automatic mseq_pkg::uinstr_t exec_word(
        input mseq_pkg::micro_op_e mop,
        input mseq_pkg::imm_t      imm,
        input mseq_pkg::uaddr_t    next
    );
        return {mseq_pkg::OPC_EXEC, mop, imm, 3'b000, next};
    endfunction

    // ------------------------------------------------------------------------
    // Entry table
    // ------------------------------------------------------------------------

    always_comb begin
        case (rom.prog_idx)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6:
                rom.entry_addr = 12'h100 + {rom.prog_idx, 4'h0};  // 16 words apart
            4'd7:    rom.entry_addr = 12'h200;  // Empty, halts at once
            4'd8:    rom.entry_addr = 12'h210;
            4'd9:    rom.entry_addr = 12'h300;  // FPREM
            4'd10:   rom.entry_addr = 12'h400;
            4'd11:   rom.entry_addr = 12'h500;
            default: rom.entry_addr = 12'h000;
        endcase
    end

    // ------------------------------------------------------------------------
    // Microcode contents
    // ------------------------------------------------------------------------

    assign prog   = rom.fetch_addr[6:4];
    assign step   = rom.fetch_addr[3:0];
    assign nxt    = rom.fetch_addr + 1'b1;
    assign n_load = (prog < 3'd4) ? 4'd2 : ((prog == 3'd4) ? 4'd1 : 4'd0);

    // ADD SUB MUL DIV use their slot number, SQRT SIN COS sit at 12 to 14
    assign op_imm = (prog < 3'd4) ? mseq_pkg::imm_t'(prog) : mseq_pkg::imm_t'(prog + 4'd8);

    always_comb begin
        rom.instr = {mseq_pkg::OPC_HALT, 28'd0};
        if (rom.fetch_addr[11:7] == 5'b00010 && prog != 3'd7) begin
            // Programs 0 to 6, loads then call, wait, result, store, return
            if (step < n_load)
                rom.instr = exec_word(step[0] ? mseq_pkg::MOP_LOAD_B : mseq_pkg::MOP_LOAD_A,
                                      '0, nxt);
            else if (step == n_load)
                rom.instr = exec_word(mseq_pkg::MOP_CALL_ARITH, op_imm, nxt);
            else if (step == n_load + 4'd1)
                rom.instr = exec_word(mseq_pkg::MOP_WAIT_ARITH, '0, nxt);
            else if (step == n_load + 4'd2)
                rom.instr = exec_word(mseq_pkg::MOP_LOAD_ARITH_RES, '0, nxt);
            else if (step == n_load + 4'd3)
                rom.instr = exec_word(mseq_pkg::MOP_STORE, '0, nxt);
            else if (step == n_load + 4'd4)
                rom.instr = {mseq_pkg::OPC_RET, 28'd0};
        end else if (rom.fetch_addr[11:4] == 8'h30) begin
            // FPREM on held operands
            case (step)
                4'd0:  rom.instr = exec_word(mseq_pkg::MOP_CALL_ARITH, 8'd3, nxt);  // Divide
                4'd1:  rom.instr = exec_word(mseq_pkg::MOP_WAIT_ARITH, '0, nxt);
                4'd2:  rom.instr = exec_word(mseq_pkg::MOP_LOAD_ARITH_RES, '0, nxt);
                4'd3:  rom.instr = exec_word(mseq_pkg::MOP_CALL_ARITH, 8'd2, nxt);  // Multiply
                4'd4:  rom.instr = exec_word(mseq_pkg::MOP_WAIT_ARITH, '0, nxt);
                4'd5:  rom.instr = exec_word(mseq_pkg::MOP_LOAD_ARITH_RES, '0, nxt);
                4'd6:  rom.instr = exec_word(mseq_pkg::MOP_CALL_ARITH, 8'd1, nxt);  // Subtract
                4'd7:  rom.instr = exec_word(mseq_pkg::MOP_WAIT_ARITH, '0, nxt);
                4'd8:  rom.instr = exec_word(mseq_pkg::MOP_LOAD_ARITH_RES, '0, nxt);
                4'd9:  rom.instr = exec_word(mseq_pkg::MOP_STORE, '0, nxt);
                4'd10: rom.instr = {mseq_pkg::OPC_RET, 28'd0};
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/mseq_if.sv ====
// ---------------------------------------------------------------------------
// Sequencer to ROM, all lookups combinational
// ---------------------------------------------------------------------------

interface rom_if ();
    mseq_pkg::prog_idx_t prog_idx;    // Program requested by host
    mseq_pkg::uaddr_t    fetch_addr;  // Current pc
    mseq_pkg::uaddr_t    entry_addr;  // First word of prog_idx
    mseq_pkg::uinstr_t   instr;       // Word at fetch_addr

    modport rom (input prog_idx, fetch_addr, output entry_addr, instr);
    modport seq (output prog_idx, fetch_addr, input entry_addr, instr);
endinterface

// ---------------------------------------------------------------------------
// Sequencer to datapath
// ---------------------------------------------------------------------------

interface exec_if ();
    logic                exec_stb;    // One cycle in EXEC for EXEC words
    mseq_pkg::micro_op_e micro_op;
    mseq_pkg::imm_t      imm;         // Op code for CALL_ARITH
    logic                arith_busy;  // Launched op not yet done

    modport ctl (output exec_stb, micro_op, imm, input arith_busy);
    modport dp  (input exec_stb, micro_op, imm, output arith_busy);
endinterface

// ==== rtl/mseq_pkg.sv ====
`include "mseq_config.svh"

package mseq_pkg;

    typedef logic [`MSEQ_DATA_W-1:0] fp80_t;      // Operand or result
    typedef logic [`MSEQ_ADDR_W-1:0] uaddr_t;     // Microcode address
    typedef logic [`MSEQ_IDX_W-1:0]  prog_idx_t;  // Host program index
    typedef logic [`MSEQ_OP_W-1:0]   arith_op_t;  // Arithmetic op code
    typedef logic [`MSEQ_IMM_W-1:0]  imm_t;       // Immediate field

    // Word layout
    // 31:28 opcode, 27:23 micro-op, 22:15 immediate, 14:12 reserved, 11:0 next
    typedef logic [31:0] uinstr_t;

    typedef enum logic [3:0] {
        OPC_EXEC = 4'h1,  // Run the micro-op field
        OPC_RET  = 4'h4,  // Ends the program with no call stack
        OPC_HALT = 4'hF   // Unprogrammed words read as this
    } opcode_e;

    typedef enum logic [4:0] {
        MOP_STORE          = 5'h02,  // Result to data bus
        MOP_LOAD_A         = 5'h05,  // data_in into operand A
        MOP_LOAD_B         = 5'h06,  // data_in into operand B
        MOP_CALL_ARITH     = 5'h10,  // Launch arithmetic unit
        MOP_WAIT_ARITH     = 5'h11,  // Hold until done
        MOP_LOAD_ARITH_RES = 5'h12   // Capture arith_result
    } micro_op_e;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_FETCH  = 3'd1,
        ST_DECODE = 3'd2,
        ST_EXEC   = 3'd3,
        ST_WAIT   = 3'd4   // Parked on the arithmetic unit
    } seq_state_e;

endpackage

// ==== rtl/mseq_config.svh ====
`ifndef MSEQ_CONFIG_SVH
`define MSEQ_CONFIG_SVH

// ---------------------------------------------------------------------------
// Widths fixed by the microinstruction format
// ---------------------------------------------------------------------------

`define MSEQ_DATA_W 80  // Extended precision word
`define MSEQ_ADDR_W 12  // 4096 microcode words
`define MSEQ_IDX_W  4   // Up to 16 host programs
`define MSEQ_OP_W   5   // Arithmetic unit op code
`define MSEQ_IMM_W  8   // Immediate field

`endif
